/* logic/cpu_pkg.sv */
package cpu_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;

    // Major opcodes of the kept subset
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Field views of one instruction word
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
        u_type_t u_type;
        b_type_t b_type;
        j_type_t j_type;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_JAL,
        BR_BEQ,
        BR_BNE
    } br_kind_e;

    typedef struct packed {
        xlen_t  pc;
        instr_t instr;
    } fetch_pkt_t;

    typedef struct packed {
        xlen_t    pc;
        alu_op_e  alu_op;
        br_kind_e br_kind;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        xlen_t    imm;
        logic     src1_pc;
        logic     src2_imm;
        logic     wb_en;
    } dec_pkt_t;

    typedef struct packed {
        xlen_t    pc;
        alu_op_e  alu_op;
        br_kind_e br_kind;
        xlen_t    operand1;
        xlen_t    operand2;
        xlen_t    rs2_val;
        xlen_t    imm;
        reg_idx_t rd;
        logic     wb_en;
    } iss_pkt_t;

    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        xlen_t    result;
        logic     wb_en;
    } retire_t;

    typedef struct packed {
        logic  valid;
        xlen_t new_pc;
    } redirect_t;

endpackage

/* logic/ifp.sv */
module ifp #(
    parameter cpu_pkg::xlen_t reset_vector = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    output cpu_pkg::xlen_t      im_req_addr,
    output logic                im_req_valid,
    input  logic                im_req_ready,
    input  cpu_pkg::instr_t     im_resp_rdata,
    input  logic                im_resp_valid,
    input  cpu_pkg::redirect_t  redirect,
    output cpu_pkg::fetch_pkt_t fetch,
    output logic                fetch_valid,
    input  logic                fetch_ready
);
    import cpu_pkg::*;

    xlen_t      pc;
    logic       outstanding;
    logic       discard;
    fetch_pkt_t pkt;
    logic       pkt_valid;
    logic       req_fire;
    logic       resp_ok;
    fetch_pkt_t resp_pkt;

    // One request in flight, and only when the packet register can drain
    assign im_req_valid = !outstanding && (!pkt_valid || fetch_ready);
    assign im_req_addr  = pc;
    assign req_fire     = im_req_valid && im_req_ready;
    assign resp_ok      = im_resp_valid && !discard;

    // pc already moved past the outstanding request; a redirect marks it for discard
    assign resp_pkt = '{pc: pc - xlen_t'(4), instr: im_resp_rdata};

    // Response goes straight to decode unless decode is busy
    assign fetch       = pkt_valid ? pkt : resp_pkt;
    assign fetch_valid = pkt_valid || resp_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= reset_vector;
            outstanding <= 1'b0;
            discard     <= 1'b0;
            pkt_valid   <= 1'b0;
        end else begin
            if (redirect.valid) begin
                pc <= redirect.new_pc;
            end else if (req_fire) begin
                pc <= pc + xlen_t'(4);
            end
            if (req_fire) begin
                outstanding <= 1'b1;
            end else if (im_resp_valid) begin
                outstanding <= 1'b0;
            end
            if (redirect.valid) begin
                discard <= (outstanding && !im_resp_valid) || req_fire;
            end else if (im_resp_valid) begin
                discard <= 1'b0;
            end
            if (redirect.valid) begin
                pkt_valid <= 1'b0;
            end else if (pkt_valid) begin
                pkt_valid <= !fetch_ready;
            end else begin
                pkt_valid <= resp_ok && !fetch_ready;
            end
        end
    end

    // Payload only, qualified by pkt_valid
    always_ff @(posedge clk) begin
        if (!pkt_valid) begin
            pkt <= resp_pkt;
        end
    end

    // A waiting request holds its address until accepted
    assert property (@(posedge clk) disable iff (!rst_n)
        im_req_valid && !im_req_ready && !redirect.valid |=>
        im_req_valid && $stable(im_req_addr));
    // Responses only ever answer a request we sent
    assert property (@(posedge clk) disable iff (!rst_n) im_resp_valid |-> outstanding);

endmodule

/* logic/dec.sv */
module dec (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::fetch_pkt_t fetch,
    input  logic                fetch_valid,
    output logic                fetch_ready,
    input  cpu_pkg::redirect_t  redirect,
    output cpu_pkg::dec_pkt_t   dpkt,
    output logic                dpkt_valid,
    input  logic                dpkt_ready
);
    import cpu_pkg::*;

    instr_t   ins;
    dec_pkt_t d;
    xlen_t    imm_i;
    xlen_t    imm_u;
    xlen_t    imm_b;
    xlen_t    imm_j;
    alu_op_e  arith_op;

    assign ins = fetch.instr;

    // Sign-extended immediates of each format
    assign imm_i = {{52{ins.i_type.imm[11]}}, ins.i_type.imm};
    assign imm_u = {{32{ins.u_type.imm[19]}}, ins.u_type.imm, 12'b0};
    assign imm_b = {{51{ins.b_type.imm12}}, ins.b_type.imm12, ins.b_type.imm11,
                    ins.b_type.imm10_5, ins.b_type.imm4_1, 1'b0};
    assign imm_j = {{43{ins.j_type.imm20}}, ins.j_type.imm20, ins.j_type.imm19_12,
                    ins.j_type.imm11, ins.j_type.imm10_1, 1'b0};

    // funct3 decode shared by OP and OP-IMM
    always_comb begin
        case (ins.r_type.funct3)
            3'b000:  arith_op = ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = ins.r_type.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        d          = '0;
        d.pc       = fetch.pc;
        d.alu_op   = ALU_ADD;
        d.br_kind  = BR_NONE;
        d.rs1      = ins.r_type.rs1;
        d.rs2      = ins.r_type.rs2;
        case (ins.r_type.opcode)
            OPC_OP_IMM: begin
                // Bit 30 only matters for the right shifts, never turns ADDI into SUB
                d.alu_op   = arith_op;
                d.rs2      = '0;
                d.imm      = imm_i;
                d.src2_imm = 1'b1;
                d.wb_en    = 1'b1;
            end
            OPC_OP: begin
                d.alu_op = (ins.r_type.funct3 == 3'b000 && ins.r_type.funct7[5]) ?
                           ALU_SUB : arith_op;
                d.wb_en  = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                d.alu_op   = (ins.r_type.opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
                d.imm      = imm_u;
                d.src1_pc  = 1'b1;
                d.src2_imm = 1'b1;
                d.wb_en    = 1'b1;
            end
            OPC_JAL: begin
                d.br_kind  = BR_JAL;
                d.imm      = imm_j;
                d.src1_pc  = 1'b1;
                d.wb_en    = 1'b1;
            end
            OPC_BRANCH: begin
                d.imm = imm_b;
                if (ins.b_type.funct3 == 3'b000) begin
                    d.br_kind = BR_BEQ;
                end else if (ins.b_type.funct3 == 3'b001) begin
                    d.br_kind = BR_BNE;
                end
            end
            default: ;
        endcase
        // Nothing without a write carries a destination
        d.rd = d.wb_en ? ins.r_type.rd : '0;
    end

    assign fetch_ready = !dpkt_valid || dpkt_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dpkt_valid <= 1'b0;
        end else if (redirect.valid) begin
            dpkt_valid <= 1'b0;
        end else if (fetch_ready) begin
            dpkt_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) begin
            dpkt <= d;
        end
    end

endmodule

/* logic/rf.sv */
module rf (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rs1,
    input  cpu_pkg::reg_idx_t rs2,
    output cpu_pkg::xlen_t    rs1_val,
    output cpu_pkg::xlen_t    rs2_val,
    input  logic              wen,
    input  cpu_pkg::reg_idx_t wdst,
    input  cpu_pkg::xlen_t    wdata
);
    import cpu_pkg::*;

    // x1..x31, x0 has no storage
    xlen_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wdst != '0) begin
            regs[wdst] <= wdata;
        end
    end

    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* logic/ix.sv */
module ix (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::dec_pkt_t   dpkt,
    input  logic                dpkt_valid,
    output logic                dpkt_ready,
    input  cpu_pkg::redirect_t  redirect,
    output cpu_pkg::reg_idx_t   rf_rs1,
    output cpu_pkg::reg_idx_t   rf_rs2,
    input  cpu_pkg::xlen_t      rf_rs1_val,
    input  cpu_pkg::xlen_t      rf_rs2_val,
    input  cpu_pkg::retire_t    fwd_ex,
    input  logic                fwd_ex_valid,
    input  cpu_pkg::retire_t    fwd_wb,
    input  logic                fwd_wb_valid,
    output cpu_pkg::iss_pkt_t   ipkt,
    output logic                ipkt_valid
);
    import cpu_pkg::*;

    xlen_t    src1;
    xlen_t    src2;
    iss_pkt_t next;

    // Newest producer wins; x0 never forwards
    function automatic xlen_t pick_src(reg_idx_t r, xlen_t rf_val,
                                       retire_t ex, logic ex_v,
                                       retire_t wb, logic wb_v);
        xlen_t v;
        v = rf_val;
        if (r != '0 && wb_v && wb.wb_en && wb.rd == r) begin
            v = wb.result;
        end
        if (r != '0 && ex_v && ex.wb_en && ex.rd == r) begin
            v = ex.result;
        end
        return v;
    endfunction

    // ip takes a packet every cycle
    assign dpkt_ready = 1'b1;

    assign rf_rs1 = dpkt.rs1;
    assign rf_rs2 = dpkt.rs2;

    assign src1 = pick_src(dpkt.rs1, rf_rs1_val, fwd_ex, fwd_ex_valid, fwd_wb, fwd_wb_valid);
    assign src2 = pick_src(dpkt.rs2, rf_rs2_val, fwd_ex, fwd_ex_valid, fwd_wb, fwd_wb_valid);

    always_comb begin
        next.pc       = dpkt.pc;
        next.alu_op   = dpkt.alu_op;
        next.br_kind  = dpkt.br_kind;
        next.operand1 = dpkt.src1_pc ? dpkt.pc : src1;
        next.operand2 = dpkt.src2_imm ? dpkt.imm : src2;
        next.rs2_val  = src2;
        next.imm      = dpkt.imm;
        next.rd       = dpkt.rd;
        next.wb_en    = dpkt.wb_en;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ipkt_valid <= 1'b0;
        end else begin
            ipkt_valid <= dpkt_valid && !redirect.valid;
        end
    end

    always_ff @(posedge clk) begin
        ipkt <= next;
    end

    // Wrong-path packets from issue and decode must not reach ip behind a taken branch
    assert property (@(posedge clk) disable iff (!rst_n)
        redirect.valid |=> !ipkt_valid ##1 !ipkt_valid);

endmodule

/* logic/ip.sv */
module ip (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::iss_pkt_t  ipkt,
    input  logic               ipkt_valid,
    output cpu_pkg::retire_t   fwd_ex,
    output logic               fwd_ex_valid,
    output cpu_pkg::redirect_t redirect,
    output logic               rf_wen,
    output cpu_pkg::reg_idx_t  rf_wdst,
    output cpu_pkg::xlen_t     rf_wdata,
    output cpu_pkg::retire_t   retire,
    output logic               retire_valid
);
    import cpu_pkg::*;

    xlen_t      alu_res;
    xlen_t      result;
    xlen_t      pc_plus4;
    xlen_t      target;
    logic [5:0] shamt;
    logic       equal;
    logic       taken;

    assign shamt = ipkt.operand2[5:0];

    always_comb begin
        alu_res = '0;
        case (ipkt.alu_op)
            ALU_ADD:    alu_res = ipkt.operand1 + ipkt.operand2;
            ALU_SUB:    alu_res = ipkt.operand1 - ipkt.operand2;
            ALU_SLT:    alu_res[0] = $signed(ipkt.operand1) < $signed(ipkt.operand2);
            ALU_SLTU:   alu_res[0] = ipkt.operand1 < ipkt.operand2;
            ALU_XOR:    alu_res = ipkt.operand1 ^ ipkt.operand2;
            ALU_OR:     alu_res = ipkt.operand1 | ipkt.operand2;
            ALU_AND:    alu_res = ipkt.operand1 & ipkt.operand2;
            ALU_SLL:    alu_res = ipkt.operand1 << shamt;
            ALU_SRL:    alu_res = ipkt.operand1 >> shamt;
            ALU_SRA:    alu_res = $signed(ipkt.operand1) >>> shamt;
            ALU_PASS_B: alu_res = ipkt.operand2;
            default:    alu_res = '0;
        endcase
    end

    // Branch resolution
    assign pc_plus4 = ipkt.pc + xlen_t'(4);
    assign target   = ipkt.pc + ipkt.imm;
    assign equal    = ipkt.operand1 == ipkt.rs2_val;

    always_comb begin
        case (ipkt.br_kind)
            BR_JAL:  taken = 1'b1;
            BR_BEQ:  taken = equal;
            BR_BNE:  taken = !equal;
            default: taken = 1'b0;
        endcase
    end

    // Link value for JAL
    assign result = (ipkt.br_kind == BR_JAL) ? pc_plus4 : alu_res;

    assign redirect = '{valid: ipkt_valid && taken, new_pc: target};

    assign fwd_ex       = '{pc: ipkt.pc, rd: ipkt.rd, result: result, wb_en: ipkt.wb_en};
    assign fwd_ex_valid = ipkt_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ipkt_valid;
        end
    end

    always_ff @(posedge clk) begin
        retire <= fwd_ex;
    end

    // Writeback straight from the retire register
    assign rf_wen   = retire_valid && retire.wb_en;
    assign rf_wdst  = retire.rd;
    assign rf_wdata = retire.result;

endmodule

/* logic/cpu.sv */
module cpu #(
    parameter cpu_pkg::xlen_t reset_vector = 64'h0000_0000_8000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    output cpu_pkg::xlen_t     im_req_addr,
    output logic               im_req_valid,
    input  logic               im_req_ready,
    input  cpu_pkg::instr_t    im_resp_rdata,
    input  logic               im_resp_valid,
    output cpu_pkg::retire_t   retire,
    output logic               retire_valid
);
    import cpu_pkg::*;

    fetch_pkt_t fetch;
    logic       fetch_valid;
    logic       fetch_ready;
    dec_pkt_t   dpkt;
    logic       dpkt_valid;
    logic       dpkt_ready;
    iss_pkt_t   ipkt;
    logic       ipkt_valid;
    redirect_t  redirect;
    retire_t    fwd_ex;
    logic       fwd_ex_valid;

    // Register file ports
    reg_idx_t   rf_rs1;
    reg_idx_t   rf_rs2;
    xlen_t      rf_rs1_val;
    xlen_t      rf_rs2_val;
    logic       rf_wen;
    reg_idx_t   rf_wdst;
    xlen_t      rf_wdata;

    ifp #(.reset_vector(reset_vector)) u_ifp (
        .clk(clk), .rst_n(rst_n),
        .im_req_addr(im_req_addr), .im_req_valid(im_req_valid), .im_req_ready(im_req_ready),
        .im_resp_rdata(im_resp_rdata), .im_resp_valid(im_resp_valid),
        .redirect(redirect),
        .fetch(fetch), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready)
    );

    dec u_dec (
        .clk(clk), .rst_n(rst_n),
        .fetch(fetch), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
        .redirect(redirect),
        .dpkt(dpkt), .dpkt_valid(dpkt_valid), .dpkt_ready(dpkt_ready)
    );

    rf u_rf (
        .clk(clk), .rst_n(rst_n),
        .rs1(rf_rs1), .rs2(rf_rs2), .rs1_val(rf_rs1_val), .rs2_val(rf_rs2_val),
        .wen(rf_wen), .wdst(rf_wdst), .wdata(rf_wdata)
    );

    // Retire register doubles as the older forwarding source
    ix u_ix (
        .clk(clk), .rst_n(rst_n),
        .dpkt(dpkt), .dpkt_valid(dpkt_valid), .dpkt_ready(dpkt_ready),
        .redirect(redirect),
        .rf_rs1(rf_rs1), .rf_rs2(rf_rs2), .rf_rs1_val(rf_rs1_val), .rf_rs2_val(rf_rs2_val),
        .fwd_ex(fwd_ex), .fwd_ex_valid(fwd_ex_valid),
        .fwd_wb(retire), .fwd_wb_valid(retire_valid),
        .ipkt(ipkt), .ipkt_valid(ipkt_valid)
    );

    ip u_ip (
        .clk(clk), .rst_n(rst_n),
        .ipkt(ipkt), .ipkt_valid(ipkt_valid),
        .fwd_ex(fwd_ex), .fwd_ex_valid(fwd_ex_valid),
        .redirect(redirect),
        .rf_wen(rf_wen), .rf_wdst(rf_wdst), .rf_wdata(rf_wdata),
        .retire(retire), .retire_valid(retire_valid)
    );

endmodule

/* sim/ref_model.svh */
`ifndef ref_model_svh
`define ref_model_svh

// Architectural state of the model
xlen_t mregs [32];
xlen_t mpc;

// Integer result for one funct3, alt selects SUB or SRA
function automatic xlen_t alu_calc(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
    xlen_t r;
    case (f3)
        3'b000:  r = alt ? a - b : a + b;
        3'b001:  r = a << b[5:0];
        3'b010:  r = xlen_t'($signed(a) < $signed(b));
        3'b011:  r = xlen_t'(a < b);
        3'b100:  r = a ^ b;
        3'b101: begin
            if (alt) begin
                r = $signed(a) >>> b[5:0];
            end else begin
                r = a >> b[5:0];
            end
        end
        3'b110:  r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
        mregs[i] = '0;
    end
    mpc = reset_vec;
endtask

// Executes the instruction at mpc and returns what should retire
task automatic model_step(output retire_t want);
    logic [31:0] w;
    reg_idx_t    rd;
    xlen_t       a;
    xlen_t       b;
    xlen_t       imm;
    xlen_t       res;
    xlen_t       npc;
    logic        wr;
    w   = prog[mpc[9:2]];
    rd  = w[11:7];
    a   = mregs[w[19:15]];
    b   = mregs[w[24:20]];
    res = '0;
    wr  = 1'b1;
    npc = mpc + 64'd4;
    case (w[6:0])
        7'b0010011: begin
            imm = {{52{w[31]}}, w[31:20]};
            res = alu_calc(w[14:12], w[14:12] == 3'b101 && w[30], a, imm);
        end
        7'b0110011: res = alu_calc(w[14:12], w[30], a, b);
        7'b0110111: res = {{32{w[31]}}, w[31:12], 12'b0};
        7'b0010111: res = mpc + {{32{w[31]}}, w[31:12], 12'b0};
        7'b1101111: begin
            res = mpc + 64'd4;
            npc = mpc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        7'b1100011: begin
            wr = 1'b0;
            // BEQ wants equal operands, BNE unequal
            if ((w[12] == 1'b0) == (a == b)) begin
                npc = mpc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
        end
        default: wr = 1'b0;
    endcase
    if (!wr) begin
        rd = '0;
    end
    want = '{pc: mpc, rd: rd, result: res, wb_en: wr};
    if (wr && rd != '0) begin
        mregs[rd] = res;
    end
    mpc = npc;
endtask

`endif

/* sim/tb_cpu.sv */
module tb_cpu;
    import cpu_pkg::*;

    localparam xlen_t reset_vec    = 64'h0000_0000_8000_0000;
    localparam int    num_retire   = 3000;
    localparam int    reset_cycles = 8;

    logic        clk;
    logic        rst_n;
    logic        im_req_ready  = 1'b0;
    instr_t      im_resp_rdata = '0;
    logic        im_resp_valid = 1'b0;
    xlen_t       im_req_addr;
    logic        im_req_valid;
    retire_t     retire;
    logic        retire_valid;
    logic [31:0] prog [256];
    int          retired = 0;

    // Responder state
    logic        req_seen;
    xlen_t       addr_seen;
    logic        pend;
    logic [2:0]  left;
    logic [7:0]  raddr;

    `include "ref_model.svh"

    cpu #(.reset_vector(reset_vec)) DUT (
        .clk(clk), .rst_n(rst_n),
        .im_req_addr(im_req_addr), .im_req_valid(im_req_valid), .im_req_ready(im_req_ready),
        .im_resp_rdata(im_resp_rdata), .im_resp_valid(im_resp_valid),
        .retire(retire), .retire_valid(retire_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_retire(retire_t got, retire_t want);
        if (got.pc !== want.pc || got.rd !== want.rd || got.wb_en !== want.wb_en ||
            (want.wb_en && got.result !== want.result)) begin
            abort_run($sformatf({"Fail at %0t: retire pc %h rd %0d wb %b result %h, ",
                "want pc %h rd %0d wb %b result %h"},
                $time, got.pc, got.rd, got.wb_en, got.result,
                want.pc, want.rd, want.wb_en, want.result));
        end
    endtask

    task automatic check_count(int got, int want);
        if (got != want) begin
            abort_run($sformatf("Fail at %0t: retired %0d instructions, want %0d",
                $time, got, want));
        end
    endtask

    // One random instruction of the kept subset, registers x0..x7 for dense dependencies
    function automatic logic [31:0] random_instr();
        logic [4:0]  rd;
        logic [4:0]  r1;
        logic [4:0]  r2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [31:0] rnd;
        logic [20:0] jo;
        logic [12:0] bo;
        int          off;
        rd  = 5'($urandom_range(0, 7));
        r1  = 5'($urandom_range(0, 7));
        r2  = 5'($urandom_range(0, 7));
        f3  = 3'($urandom);
        imm = 12'($urandom);
        rnd = $urandom;
        off = int'($urandom_range(0, 128)) - 64;
        if (off == 0) begin
            off = 1;
        end
        jo = 21'(off * 4);
        bo = 13'(off * 4);
        case ($urandom_range(0, 9))
            0, 1, 2: begin
                // Shift immediates keep only the amount and the SRAI mode bit
                if (f3 == 3'b001) begin
                    imm[11:6] = 6'b0;
                end else if (f3 == 3'b101) begin
                    imm[11:6] = {1'b0, imm[10], 4'b0};
                end
                return {imm, r1, f3, rd, OPC_OP_IMM};
            end
            3, 4, 5: begin
                return {1'b0, rnd[0] && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                        r2, r1, f3, rd, OPC_OP};
            end
            6: return {rnd[19:0], rd, rnd[20] ? OPC_LUI : OPC_AUIPC};
            7: return {jo[20], jo[10:1], jo[11], jo[19:12], rd, OPC_JAL};
            default: begin
                return {bo[12], bo[10:5], r2, r1, 2'b00, rnd[0], bo[4:1], bo[11], OPC_BRANCH};
            end
        endcase
    endfunction

    always @(negedge clk) begin
        req_seen  = im_req_valid && im_req_ready;
        addr_seen = im_req_addr;
    end

    // Instruction memory with random ready and 1 to 4 cycles of latency
    always @(posedge clk) begin : responder
        int unsigned lat;
        if (!rst_n) begin
            im_req_ready  <= 1'b0;
            im_resp_valid <= 1'b0;
            pend          <= 1'b0;
        end else begin
            im_req_ready  <= $urandom_range(0, 3) != 0;
            im_resp_valid <= 1'b0;
            if (req_seen) begin
                lat = $urandom_range(1, 4);
                if (lat == 1) begin
                    im_resp_valid <= 1'b1;
                    im_resp_rdata <= prog[addr_seen[9:2]];
                end else begin
                    pend  <= 1'b1;
                    left  <= 3'(lat - 1);
                    raddr <= addr_seen[9:2];
                end
            end else if (pend) begin
                if (left == 3'd1) begin
                    im_resp_valid <= 1'b1;
                    im_resp_rdata <= prog[raddr];
                    pend          <= 1'b0;
                end else begin
                    left <= left - 3'd1;
                end
            end
        end
    end

    always @(negedge clk) begin : monitor
        retire_t want;
        if (!rst_n) begin
            if (retire_valid !== 1'b0) begin
                abort_run("Retire trace was active while the core was held in reset");
            end
        end else if (retire_valid && retired < num_retire) begin
            model_step(want);
            check_retire(retire, want);
            retired++;
        end
    end

    // A short count at the limit means the core stalled
    initial begin
        repeat (reset_cycles + num_retire * 20) @(posedge clk);
        $display("Timeout: the core did not retire all instructions within the cycle limit");
        check_count(retired, num_retire);
        abort_run("Timeout: the run reached the cycle limit");
    end

    initial begin
        void'($urandom(32'h02646a88));
        rst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            prog[i] = random_instr();
        end
        reset_model();
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        wait (retired == num_retire);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+sim
logic/cpu_pkg.sv
logic/ifp.sv
logic/dec.sv
logic/rf.sv
logic/ix.sv
logic/ip.sv
logic/cpu.sv
sim/tb_cpu.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_cpu -o tb_cpu

# The simulation status is not trusted, the log decides
./obj_dir/tb_cpu | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
echo "simulation did not pass"
exit 1
